// ==== tb.f ====
+incdir+hdl
+incdir+verif
hdl/isa_pkg.sv
hdl/ctl_pkg.sv
hdl/phase_gen.sv
hdl/imm_gen.sv
hdl/alu_ctl_gen.sv
hdl/datapath_ctl.sv
hdl/controller_top.sv
verif/tb_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the control unit testbench with Verilator, run it, scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/10ps \
	-f tb.f --top-module tb_controller -o tb_controller

./obj_dir/tb_controller > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

// ==== verif/tb_vectors.svh ====
// stimulus table for the control unit testbench
// one row per instruction with expected immediate, ALU control,
// pc select, writeback and store byte mask
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ex_alu and wb_alu hold {a_sel, b_sel, alu_code}
typedef struct packed {
	logic [31:0] instr;
	logic [31:0] addr;
	logic [31:0] alu_out;
	logic [31:0] imm;
	logic [5:0]  ex_alu;
	logic [5:0]  wb_alu;
	logic        pc_sel;
	logic        rd_ld;
	logic [1:0]  rd_sel;
	logic [3:0]  wrbits;
} vec_t;

localparam int NUM_VEC = 39;

// columns: instr, addr, alu_out at WB, imm, EX alu, WB alu,
// pc_sel, rd_ld, rd_sel (0 mem, 1 link, 2 alu), store mask
localparam vec_t VECTORS [NUM_VEC] = '{
	// register arithmetic, rs2 = x2
	'{32'h00200033, 32'h0, 32'h0, 32'h00000000, 6'h08, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h40200033, 32'h0, 32'h0, 32'h00000000, 6'h09, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00201033, 32'h0, 32'h0, 32'h00000000, 6'h0d, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00202033, 32'h0, 32'h0, 32'h00000000, 6'h04, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00203033, 32'h0, 32'h0, 32'h00000000, 6'h06, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00204033, 32'h0, 32'h0, 32'h00000000, 6'h0a, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00205033, 32'h0, 32'h0, 32'h00000000, 6'h0e, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h40205033, 32'h0, 32'h0, 32'h00000000, 6'h0f, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00206033, 32'h0, 32'h0, 32'h00000000, 6'h0b, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00207033, 32'h0, 32'h0, 32'h00000000, 6'h0c, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	// immediate arithmetic, shifts carry a bare shamt
	'{32'hFFB00013, 32'h0, 32'h0, 32'hFFFFFFFB, 6'h18, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h06402013, 32'h0, 32'h0, 32'h00000064, 6'h14, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h7FF03013, 32'h0, 32'h0, 32'h000007FF, 6'h16, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'hFFF04013, 32'h0, 32'h0, 32'hFFFFFFFF, 6'h1a, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h12306013, 32'h0, 32'h0, 32'h00000123, 6'h1b, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h80007013, 32'h0, 32'h0, 32'hFFFFF800, 6'h1c, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h00301013, 32'h0, 32'h0, 32'h00000003, 6'h1d, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h01F05013, 32'h0, 32'h0, 32'h0000001F, 6'h1e, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h40705013, 32'h0, 32'h0, 32'h00000007, 6'h1f, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	// lui, auipc, jal, jalr
	'{32'h12345037, 32'h0, 32'h0, 32'h12345000, 6'h10, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'hFFFFF017, 32'h0, 32'h0, 32'hFFFFF000, 6'h38, 6'h00, 1'b0, 1'b1, 2'd2, 4'h0},
	'{32'h4DFAB06F, 32'h0, 32'h0, 32'h000ABCDE, 6'h38, 6'h00, 1'b1, 1'b1, 2'd1, 4'h0},
	'{32'hFF000067, 32'h0, 32'h0, 32'hFFFFFFF0, 6'h18, 6'h00, 1'b1, 1'b1, 2'd1, 4'h0},
	// branches, offset -204, taken when alu_out is 1
	'{32'hF2200AE3, 32'h0, 32'h1, 32'hFFFFFF34, 6'h38, 6'h02, 1'b1, 1'b0, 2'd0, 4'h0},
	'{32'hF2200AE3, 32'h0, 32'h0, 32'hFFFFFF34, 6'h38, 6'h02, 1'b0, 1'b0, 2'd0, 4'h0},
	'{32'hF2201AE3, 32'h0, 32'h1, 32'hFFFFFF34, 6'h38, 6'h03, 1'b1, 1'b0, 2'd0, 4'h0},
	'{32'hF2204AE3, 32'h0, 32'h0, 32'hFFFFFF34, 6'h38, 6'h04, 1'b0, 1'b0, 2'd0, 4'h0},
	'{32'hF2205AE3, 32'h0, 32'h1, 32'hFFFFFF34, 6'h38, 6'h05, 1'b1, 1'b0, 2'd0, 4'h0},
	'{32'hF2206AE3, 32'h0, 32'h0, 32'hFFFFFF34, 6'h38, 6'h06, 1'b0, 1'b0, 2'd0, 4'h0},
	'{32'hF2207AE3, 32'h0, 32'h1, 32'hFFFFFF34, 6'h38, 6'h07, 1'b1, 1'b0, 2'd0, 4'h0},
	// stores, offset -12, lanes from addr[1:0]
	'{32'hFE200A23, 32'h1000, 32'h0, 32'hFFFFFFF4, 6'h18, 6'h00, 1'b0, 1'b0, 2'd0, 4'h1},
	'{32'hFE200A23, 32'h1001, 32'h0, 32'hFFFFFFF4, 6'h18, 6'h00, 1'b0, 1'b0, 2'd0, 4'h2},
	'{32'hFE200A23, 32'h1002, 32'h0, 32'hFFFFFFF4, 6'h18, 6'h00, 1'b0, 1'b0, 2'd0, 4'h4},
	'{32'hFE200A23, 32'h1003, 32'h0, 32'hFFFFFFF4, 6'h18, 6'h00, 1'b0, 1'b0, 2'd0, 4'h8},
	'{32'hFE201A23, 32'h2000, 32'h0, 32'hFFFFFFF4, 6'h18, 6'h00, 1'b0, 1'b0, 2'd0, 4'h3},
	'{32'hFE201A23, 32'h2002, 32'h0, 32'hFFFFFFF4, 6'h18, 6'h00, 1'b0, 1'b0, 2'd0, 4'hC},
	'{32'hFE202A23, 32'h3004, 32'h0, 32'hFFFFFFF4, 6'h18, 6'h00, 1'b0, 1'b0, 2'd0, 4'hF},
	// lw, then fence as the unsupported opcode
	'{32'h01002003, 32'h4001, 32'h0, 32'h00000010, 6'h18, 6'h00, 1'b0, 1'b1, 2'd0, 4'h0},
	'{32'h0000000F, 32'h0, 32'h0, 32'h00000000, 6'h00, 6'h00, 1'b0, 1'b0, 2'd0, 4'h0}
};

`endif

// ==== verif/tb_controller.sv ====
// testbench of the multicycle RV32I control unit
// clock and reset, table-driven instruction loop
// per-phase checks of enables, ALU control, immediate, register indices
`timescale 1ns/10ps
`default_nettype none

module tb_controller
	import isa_pkg::*;
	import ctl_pkg::*;
();

	localparam int HALF_PERIOD   = 50;
	localparam int RESET_CYCLES  = 16;
	localparam int IDLE_CYCLES   = 2;
	localparam int IR_LD_TIMEOUT = 10;

	// phase position inside one instruction
	localparam int IDX_IF = 0;
	localparam int IDX_DE = 1;
	localparam int IDX_EX = 2;
	localparam int IDX_WB = 3;

	// opcodes that decide which register fields are free
	localparam logic [6:0] OP_LUI    = 7'h37;
	localparam logic [6:0] OP_AUIPC  = 7'h17;
	localparam logic [6:0] OP_JAL    = 7'h6F;
	localparam logic [6:0] OP_STORE  = 7'h23;
	localparam logic [6:0] OP_BRANCH = 7'h63;

	logic      clk = 1'b0;
	logic      rst_n;
	instr_t    ir;
	xword_t    addr;
	xword_t    alu_out;
	seq_ctl_s  seq;
	alu_ctl_s  alu;
	xword_t    imm;
	reg_addr_s regs;

	int errors;
	int checks;
	bit timed_out;

	`include "tb_vectors.svh"

	// ====================
	// clock and DUT
	// ====================
	always #HALF_PERIOD clk = ~clk;

	controller_top dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.ir      (ir),
		.addr    (addr),
		.alu_out (alu_out),
		.seq     (seq),
		.alu     (alu),
		.imm     (imm),
		.regs    (regs)
	);

	// ====================
	// checks
	// ====================
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// nothing enabled and ALU control zero in reset and IDLE
	task automatic check_idle();
		check_val("seq", 32'(seq), 32'h0);
		check_val("alu", 32'(alu), 32'h0);
	endtask

	// expected control word of one phase from the table row
	task automatic check_phase(input int idx, input vec_t v, input instr_t instr);
		logic [4:0] exp_strb;
		logic [5:0] exp_alu;
		logic       wb;
		wb = (idx == IDX_WB);
		// strobes from ir_ld down to pc_ld
		case (idx)
			IDX_IF:  exp_strb = 5'b10000;
			IDX_DE:  exp_strb = 5'b01100;
			IDX_EX:  exp_strb = 5'b00010;
			default: exp_strb = 5'b00001;
		endcase
		exp_alu = (idx == IDX_EX) ? v.ex_alu : (wb ? v.wb_alu : 6'h0);
		check_val("strobes", 32'({seq.ir_ld, seq.a_ld, seq.b_ld, seq.c_ld, seq.pc_ld}),
			32'(exp_strb));
		check_val("mem_sel", 32'(seq.mem_sel), 32'(wb));
		check_val("pc_sel", 32'(seq.pc_sel), 32'(wb & v.pc_sel));
		check_val("rd_ld", 32'(seq.rd_ld), 32'(wb & v.rd_ld));
		check_val("rd_sel", 32'(seq.rd_sel), wb ? 32'(v.rd_sel) : 32'h0);
		check_val("mem_write", 32'(seq.mem_write), 32'(wb & (|v.wrbits)));
		check_val("mem_wrbits", 32'(seq.mem_wrbits), wb ? 32'(v.wrbits) : 32'h0);
		check_val("alu", 32'(alu), 32'(exp_alu));
		// IR still holds the previous instruction in IF
		if (idx != IDX_IF) begin
			check_val("imm", imm, v.imm);
		end
		if (idx == IDX_DE) begin
			check_val("rs1_addr", 32'(regs.rs1_addr), 32'(instr[19:15]));
			check_val("rs2_addr", 32'(regs.rs2_addr), 32'(instr[24:20]));
			check_val("rd_addr", 32'(regs.rd_addr), 32'(instr[11:7]));
		end
	endtask

	// counts falling edges until ir_ld shows
	task automatic wait_ir_ld(output int cycles, output bit seen);
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < IR_LD_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			seen = seq.ir_ld;
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		vec_t       v;
		instr_t     instr;
		logic [6:0] op;
		int         cycles;
		bit         seen;
		int         row_errors;
		int         rows_done;
		int         i;

		void'($urandom(32'h6bb8ae36));
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		rows_done = 0;
		rst_n   <= 1'b0;
		ir      <= '0;
		addr    <= '0;
		alu_out <= '0;

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		rst_n <= 1'b1;
		// IDLE until the second rising edge after release
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_idle();
		end
		$display("reset and idle cycles done, %0d errors", errors);

		for (i = 0; i < NUM_VEC && !timed_out; i++) begin
			v          = VECTORS[i];
			row_errors = errors;
			wait_ir_ld(cycles, seen);
			if (!seen) begin
				$display("timeout: no ir_ld within %0d cycles before row %0d",
					IR_LD_TIMEOUT, i);
				timed_out = 1'b1;
			end else begin
				// IF follows WB or IDLE directly
				check_val("cycles to ir_ld", cycles, 1);
				check_phase(IDX_IF, v, ir);
				instr = v.instr;
				op    = instr[6:0];
				// rs1 is free unless U or J format
				if (op != OP_LUI && op != OP_AUIPC && op != OP_JAL) begin
					instr[19:15] = 5'($urandom);
				end
				// rd bits hold the immediate in S and B format
				if (op != OP_STORE && op != OP_BRANCH) begin
					instr[11:7] = 5'($urandom);
				end
				// IR loads on this edge
				@(posedge clk);
				ir      <= instr;
				addr    <= v.addr;
				alu_out <= (op == OP_BRANCH) ? v.alu_out : $urandom;
				@(negedge clk);
				check_phase(IDX_DE, v, instr);
				@(negedge clk);
				check_phase(IDX_EX, v, instr);
				@(negedge clk);
				check_phase(IDX_WB, v, instr);
				rows_done++;
				$display("row %0d instr %h: %0d errors", i, instr, errors - row_errors);
			end
		end

		$display("rows %0d of %0d, checks %0d, errors %0d", rows_done, NUM_VEC,
			checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/controller_top.sv ====
// control unit of the multicycle RV32I core
// phase sequencer and the three control word generators
// register indices sliced from the IR
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module controller_top
	import isa_pkg::*;
	import ctl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  instr_t    ir,
	input  xword_t    addr,
	input  xword_t    alu_out,
	output seq_ctl_s  seq,
	output alu_ctl_s  alu,
	output xword_t    imm,
	output reg_addr_s regs
);

	phase_e phase;

	// ====================
	// sequencer
	// ====================
	phase_gen phase_gen_i (
		.clk   (clk),
		.rst_n (rst_n),
		.phase (phase)
	);

	// ====================
	// control word
	// ====================
	// immediate depends on the IR only
	imm_gen imm_gen_i (
		.ir  (ir),
		.imm (imm)
	);

	alu_ctl_gen alu_ctl_gen_i (
		.phase (phase),
		.ir    (ir),
		.alu   (alu)
	);

	datapath_ctl datapath_ctl_i (
		.phase   (phase),
		.ir      (ir),
		.addr    (addr),
		.alu_out (alu_out),
		.seq     (seq)
	);

	// register file indices, valid in every phase
	assign regs.rs1_addr = ir[`RS1_MSB:`RS1_LSB];
	assign regs.rs2_addr = ir[`RS2_MSB:`RS2_LSB];
	assign regs.rd_addr  = ir[`RD_MSB:`RD_LSB];

endmodule

`default_nettype wire

// ==== hdl/datapath_ctl.sv ====
// sequencing enables for the datapath
// PC, memory, IR, register file and A, B, C loads
// writeback select and store byte mask
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module datapath_ctl
	import isa_pkg::*;
	import ctl_pkg::*;
(
	input  phase_e   phase,
	input  instr_t   ir,
	input  xword_t   addr,
	input  xword_t   alu_out,
	output seq_ctl_s seq
);

	opcode_e                opcode;
	funct3_t                funct3;
	logic [`LANE_SEL_W-1:0] lane;
	logic                   taken;
	byte_mask_t             st_mask;

	assign opcode = opcode_e'(ir[`OPC_MSB:`OPC_LSB]);
	assign funct3 = ir[`F3_MSB:`F3_LSB];
	// byte offset inside the word
	assign lane   = addr[`LANE_SEL_W-1:0];
	// compare result from the ALU in WB
	assign taken  = (alu_out == xword_t'(1));

	// lanes written by a store
	always_comb begin
		case (funct3)
			f3_sb:   st_mask = byte_mask_t'(1) << lane;
			// halfword aligned on addr[1]
			f3_sh:   st_mask = lane[1] ? 4'b1100 : 4'b0011;
			f3_sw:   st_mask = 4'b1111;
			default: st_mask = '0;
		endcase
	end

	always_comb begin
		seq = '0;
		case (phase)
			PH_IF: begin
				seq.ir_ld = 1'b1;
			end
			// operand registers from the register file
			PH_DE: begin
				seq.a_ld = 1'b1;
				seq.b_ld = 1'b1;
			end
			PH_EX: begin
				seq.c_ld = 1'b1;
			end
			PH_WB: begin
				seq.pc_ld   = 1'b1;
				seq.mem_sel = 1'b1;
				// jumps always, branches on a true compare
				seq.pc_sel  = (opcode == jal) || (opcode == jalr) ||
					(opcode == branch && taken);
				case (opcode)
					load: begin
						seq.rd_sel = RD_MEM;
						seq.rd_ld  = 1'b1;
					end
					// return address into rd
					jal, jalr: begin
						seq.rd_sel = RD_LINK;
						seq.rd_ld  = 1'b1;
					end
					op_reg, op_imm, lui, auipc: begin
						seq.rd_sel = RD_ALU;
						seq.rd_ld  = 1'b1;
					end
					// unknown widths write nothing
					store: begin
						seq.mem_wrbits = st_mask;
						seq.mem_write  = |st_mask;
					end
					default: begin
						seq.rd_ld = 1'b0;
					end
				endcase
			end
			// IDLE and illegal codes keep everything off
			default: begin
				seq = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/alu_ctl_gen.sv ====
// ALU control generator
// operand selects and function code per phase
// EX computes results and targets, WB does branch compares
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module alu_ctl_gen
	import isa_pkg::*;
	import ctl_pkg::*;
(
	input  phase_e   phase,
	input  instr_t   ir,
	output alu_ctl_s alu
);

	opcode_e opcode;
	funct3_t funct3;
	funct7_t funct7;

	assign opcode = opcode_e'(ir[`OPC_MSB:`OPC_LSB]);
	assign funct3 = ir[`F3_MSB:`F3_LSB];
	assign funct7 = ir[`F7_MSB:`F7_LSB];

	// arithmetic code from funct3 and funct7
	// sub only exists for register operands
	function automatic alu_code_e arith_code(input funct3_t f3, input funct7_t f7,
		input logic is_reg);
		alu_code_e code;
		case (f3)
			f3_add:  code = (is_reg && f7 == f7_alt) ? ALU_SUB : ALU_ADD;
			f3_sll:  code = ALU_SLL;
			f3_slt:  code = ALU_LT;
			f3_sltu: code = ALU_LTU;
			f3_xor:  code = ALU_XOR;
			// srai has the alt pattern in imm[11:5]
			f3_srl:  code = (f7 == f7_base) ? ALU_SRL : ALU_SRA;
			f3_or:   code = ALU_OR;
			f3_and:  code = ALU_AND;
			default: code = ALU_PASS_B;
		endcase
		return code;
	endfunction

	// compare code per branch type
	function automatic alu_code_e branch_code(input funct3_t f3);
		alu_code_e code;
		case (f3)
			f3_beq:  code = ALU_EQ;
			f3_bne:  code = ALU_NE;
			f3_blt:  code = ALU_LT;
			f3_bge:  code = ALU_GE;
			f3_bltu: code = ALU_LTU;
			f3_bgeu: code = ALU_GEU;
			default: code = ALU_PASS_B;
		endcase
		return code;
	endfunction

	always_comb begin
		alu = '0;
		if (phase == PH_EX) begin
			case (opcode)
				op_reg: begin
					alu.alu_code = arith_code(funct3, funct7, 1'b1);
				end
				op_imm: begin
					alu.b_sel    = 1'b1;
					alu.alu_code = arith_code(funct3, funct7, 1'b0);
				end
				// rs1 plus offset
				load, store, jalr: begin
					alu.b_sel    = 1'b1;
					alu.alu_code = ALU_ADD;
				end
				lui: begin
					alu.b_sel    = 1'b1;
					alu.alu_code = ALU_PASS_B;
				end
				// PC plus offset, branch target lands in C
				auipc, jal, branch: begin
					alu.a_sel    = 1'b1;
					alu.b_sel    = 1'b1;
					alu.alu_code = ALU_ADD;
				end
				default: begin
					alu = '0;
				end
			endcase
		end else if (phase == PH_WB && opcode == branch) begin
			// rs1 against rs2, result decides pc_sel
			alu.alu_code = branch_code(funct3);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
// immediate generator
// sign-extended I, S, B, U, J immediates and shift amounts
// selected by the opcode of the IR
`timescale 1ns/10ps
`default_nettype none
`include "rv_consts.svh"

module imm_gen
	import isa_pkg::*;
(
	input  instr_t ir,
	output xword_t imm
);

	opcode_e   opcode;
	funct3_t   funct3;
	logic      sign;
	reg_addr_t shamt;

	assign opcode = opcode_e'(ir[`OPC_MSB:`OPC_LSB]);
	assign funct3 = ir[`F3_MSB:`F3_LSB];
	assign sign   = ir[`SIGN_BIT];
	// shift amount sits in the rs2 field
	assign shamt  = ir[`RS2_MSB:`RS2_LSB];

	always_comb begin
		case (opcode)
			// I format
			load, jalr: begin
				imm = {{20{sign}}, ir[31:20]};
			end
			op_imm: begin
				// shifts carry shamt, not a signed immediate
				if (funct3 == f3_sll || funct3 == f3_srl) begin
					imm = {{(`XLEN-`REG_ADDR_W){1'b0}}, shamt};
				end else begin
					imm = {{20{sign}}, ir[31:20]};
				end
			end
			// S format, split around the funct3 field
			store: begin
				imm = {{20{sign}}, ir[`F7_MSB:`F7_LSB], ir[`RD_MSB:`RD_LSB]};
			end
			// B format, bit 0 implicit
			branch: begin
				imm = {{19{sign}}, sign, ir[7], ir[30:25], ir[11:8], 1'b0};
			end
			// U format, low 12 bits zero
			lui, auipc: begin
				imm = {ir[31:12], 12'b0};
			end
			// J format, bit 0 implicit
			jal: begin
				imm = {{11{sign}}, sign, ir[19:12], ir[20], ir[30:21], 1'b0};
			end
			// op_reg and unknown opcodes
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/phase_gen.sv ====
// phase sequencer of the multicycle controller
// one-hot phase register, IDLE then IF DE EX WB repeating
`timescale 1ns/10ps
`default_nettype none

module phase_gen
	import ctl_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	output phase_e phase
);

	phase_e phase_nxt;
	// set one cycle after reset release
	logic run;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run   <= 1'b0;
			phase <= PH_IDLE;
		end else begin
			run   <= 1'b1;
			phase <= phase_nxt;
		end
	end

	// IDLE held for one full cycle after release
	always_comb begin
		case (phase)
			PH_IDLE: phase_nxt = run ? PH_IF : PH_IDLE;
			PH_IF:   phase_nxt = PH_DE;
			PH_DE:   phase_nxt = PH_EX;
			PH_EX:   phase_nxt = PH_WB;
			PH_WB:   phase_nxt = PH_IF;
			// illegal one-hot code falls back to idle
			default: phase_nxt = PH_IDLE;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/ctl_pkg.sv ====
// control unit types
// phase enum, ALU function codes, writeback select
// store byte mask
// ALU, sequencing and register address structs
`default_nettype none
`include "rv_consts.svh"

package ctl_pkg;
	import isa_pkg::*;

	// ====================
	// phase
	// ====================
	// one-hot, IDLE only after reset
	typedef enum logic [`PHASE_W-1:0] {
		PH_IDLE = 5'b00001,
		PH_IF   = 5'b00010,
		PH_DE   = 5'b00100,
		PH_EX   = 5'b01000,
		PH_WB   = 5'b10000
	} phase_e;

	// ====================
	// ALU
	// ====================
	// compares return 1 or 0 in alu_out
	typedef enum logic [`ALU_CTL_W-1:0] {
		ALU_PASS_B = 4'b0000,
		ALU_EQ     = 4'b0010,
		ALU_NE     = 4'b0011,
		ALU_LT     = 4'b0100,
		ALU_GE     = 4'b0101,
		ALU_LTU    = 4'b0110,
		ALU_GEU    = 4'b0111,
		ALU_ADD    = 4'b1000,
		ALU_SUB    = 4'b1001,
		ALU_XOR    = 4'b1010,
		ALU_OR     = 4'b1011,
		ALU_AND    = 4'b1100,
		ALU_SLL    = 4'b1101,
		ALU_SRL    = 4'b1110,
		ALU_SRA    = 4'b1111
	} alu_code_e;

	// a_sel picks PC, b_sel picks the immediate
	typedef struct packed {
		logic      a_sel;
		logic      b_sel;
		alu_code_e alu_code;
	} alu_ctl_s;

	// ====================
	// sequencing
	// ====================
	// register file write source
	typedef enum logic [1:0] {
		RD_MEM  = 2'd0,
		RD_LINK = 2'd1,
		RD_ALU  = 2'd2
	} rd_sel_e;

	typedef logic [`BYTE_LANES-1:0] byte_mask_t;

	typedef struct packed {
		// PC loads the target when set
		logic       pc_sel;
		logic       pc_ld;
		// memory address from the data address bus when set
		logic       mem_sel;
		logic       mem_write;
		byte_mask_t mem_wrbits;
		logic       ir_ld;
		rd_sel_e    rd_sel;
		logic       rd_ld;
		logic       a_ld;
		logic       b_ld;
		logic       c_ld;
	} seq_ctl_s;

	// register file indices, straight from the IR
	typedef struct packed {
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		reg_addr_t rd_addr;
	} reg_addr_s;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
// RV32I instruction-set types
// instruction and data words, register index
// funct3 and funct7 field types
// opcode enum and funct enums per instruction class
`default_nettype none
`include "rv_consts.svh"

package isa_pkg;

	// ====================
	// words and fields
	// ====================
	typedef logic [`XLEN-1:0] instr_t;
	typedef logic [`XLEN-1:0] xword_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`F3_W-1:0] funct3_t;
	typedef logic [`F7_W-1:0] funct7_t;

	// ====================
	// opcodes
	// ====================
	// only the classes the controller decodes
	typedef enum logic [`OPC_W-1:0] {
		lui    = 7'b0110111,
		auipc  = 7'b0010111,
		jal    = 7'b1101111,
		jalr   = 7'b1100111,
		branch = 7'b1100011,
		load   = 7'b0000011,
		store  = 7'b0100011,
		op_imm = 7'b0010011,
		op_reg = 7'b0110011
	} opcode_e;

	// arithmetic funct3, shared by op_reg and op_imm
	typedef enum funct3_t {
		f3_add  = 3'b000,
		f3_sll  = 3'b001,
		f3_slt  = 3'b010,
		f3_sltu = 3'b011,
		f3_xor  = 3'b100,
		f3_srl  = 3'b101,
		f3_or   = 3'b110,
		f3_and  = 3'b111
	} alu_f3_e;

	// branch compares, 010 and 011 unused
	typedef enum funct3_t {
		f3_beq  = 3'b000,
		f3_bne  = 3'b001,
		f3_blt  = 3'b100,
		f3_bge  = 3'b101,
		f3_bltu = 3'b110,
		f3_bgeu = 3'b111
	} br_f3_e;

	// store widths
	typedef enum funct3_t {
		f3_sb = 3'b000,
		f3_sh = 3'b001,
		f3_sw = 3'b010
	} st_f3_e;

	// alt selects sub and arithmetic right shift
	typedef enum funct7_t {
		f7_base = 7'b0000000,
		f7_alt  = 7'b0100000
	} funct7_e;

endpackage

`default_nettype wire

// ==== hdl/rv_consts.svh ====
// widths of the RV32I datapath and control words
// bit positions of the instruction word fields
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ====================
// widths
// ====================
`define XLEN        32
`define REG_ADDR_W  5
`define BYTE_LANES  4
// lane select bits taken from the low address
`define LANE_SEL_W  2
`define ALU_CTL_W   4
// one-hot, IDLE has its own bit
`define PHASE_W     5

// ====================
// instruction fields
// ====================
`define OPC_W       7
`define F3_W        3
`define F7_W        7
`define OPC_MSB     6
`define OPC_LSB     0
`define RD_MSB      11
`define RD_LSB      7
`define F3_MSB      14
`define F3_LSB      12
`define RS1_MSB     19
`define RS1_LSB     15
`define RS2_MSB     24
`define RS2_LSB     20
`define F7_MSB      31
`define F7_LSB      25
// immediate sign is always the top bit
`define SIGN_BIT    31

`endif
